// File: compile.f
+incdir+verilog
verilog/mcont_pkg.sv
verilog/chn_apb_regs.sv
verilog/chn_buffer.sv
verilog/chn_read_seq.sv
verilog/chnbuf_read_reg.sv
verilog/wr_data_merge.sv
verilog/mcont_wr_path.sv
bench/mcont_wr_path_chk.sv
bench/mcont_wr_path_tb.sv

// File: bench/mcont_wr_path_tb.sv
// testbench for the memory controller write path
// fills all channel buffers over APB, then runs a table of commands and
// checks output words, first word latency, done status and rejections
`timescale 1ns/1ns
`include "mcont_params.svh"

module mcont_wr_path_tb
    import mcont_pkg::*;
;

    // one table row with a command and its expected outcome
    typedef struct packed {
        logic [`MC_CHN_W-1:0] chn;
        logic [`MC_BUF_AW:0]  len;
        logic                 exp_err;  // command must be rejected
        logic                 overlap;  // send a second command while busy
        logic                 refill;   // new buffer contents before the command
    } cmd_entry_t;

    localparam int n_entries = 8;
    localparam int fill_cycles = (1 << `MC_BUF_AW) * 4; // two writes per word at two cycles each
    // start comes one cycle after accept and the first word at S+6+latency
    localparam int first_lat = 7 + `MC_CHN_LATENCY;

    cmd_entry_t cmd_tab [n_entries] = '{
        '{2'd0, 8'd8,   1'b0, 1'b0, 1'b0},  // short burst
        '{2'd0, 8'd3,   1'b0, 1'b0, 1'b0},  // same channel again restarts at word 0
        '{2'd1, 8'd128, 1'b0, 1'b0, 1'b0},  // whole buffer
        '{2'd2, 8'd0,   1'b1, 1'b0, 1'b0},  // zero length
        '{2'd3, 8'd20,  1'b0, 1'b1, 1'b0},  // dropped command during this burst
        '{2'd1, 8'd5,   1'b0, 1'b0, 1'b1},  // refilled channel
        '{2'd2, 8'd6,   1'b0, 1'b0, 1'b0},
        '{2'd0, 8'd8,   1'b0, 1'b0, 1'b0}   // untouched by the refill
    };

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`MC_APB_AW-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    mem_word_t             mem_out;

    logic [`MC_DW-1:0]      model [`MC_NUM_CHN][1 << `MC_BUF_AW]; // buffer images
    logic [`MC_NUM_CHN-1:0] stat_model;                           // expected done bits
    logic [`MC_DW-1:0]      words [$];   // collected output words
    int                     stamps [$];  // cycle of each word
    integer                 seed = 32'h3033_ea86;
    int                     cyc = 0;
    int                     cyc_limit;
    int                     acc_cycle;   // cycle of the last APB access phase
    int                     errors = 0;

    mcont_wr_path DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_limit) begin
            $display("timeout: test did not finish within %0d cycles, run aborted", cyc_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // output monitor samples the registered stream mid-cycle
    always @(negedge clk) begin
        if (!rst && mem_out.valid) begin
            words.push_back(mem_out.data);
            stamps.push_back(cyc);
        end
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // one APB transfer starting 1 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [`MC_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(posedge clk);
        #1 penable = 1'b1;     // access phase
        @(negedge clk);
        rdata     = prdata;
        err       = pslverr;
        acc_cycle = cyc;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    function automatic logic [`MC_APB_AW-1:0] fill_addr(input int c, input int w, input logic h);
        fill_addr = {1'b0, 2'(c), 7'(w), h, 2'b00}; // bit 12 low selects fill
    endfunction

    function automatic logic [31:0] cmd_word(input logic [1:0] c, input logic [7:0] len);
        cmd_word = '0;
        cmd_word[`MC_CMD_CHN_LSB +: `MC_CHN_W] = c;
        cmd_word[`MC_BUF_AW:0] = len;
    endfunction

    task automatic fill_channel(input int c);
        logic [31:0] rdat;
        logic        err;
        for (int w = 0; w < (1 << `MC_BUF_AW); w++) begin
            model[c][w] = {$random(seed), $random(seed)};
            apb_xfer(1'b1, fill_addr(c, w, 1'b0), model[c][w][31:0], rdat, err);
            apb_xfer(1'b1, fill_addr(c, w, 1'b1), model[c][w][63:32], rdat, err);
        end
    endtask

    task automatic run_entry(input cmd_entry_t e);
        logic [31:0] rdat;
        logic        err;
        int          acc;
        if (e.refill) fill_channel(e.chn);
        words.delete();
        stamps.delete();
        apb_xfer(1'b1, `MC_CMD_ADDR, cmd_word(e.chn, e.len), rdat, err);
        acc = acc_cycle;
        check_value(err, e.exp_err, "command pslverr");
        if (!e.exp_err) stat_model[e.chn] = 1'b0;  // accepted command clears its bit
        if (e.overlap) begin
            apb_xfer(1'b1, `MC_CMD_ADDR, cmd_word(e.chn ^ 2'd1, 8'd4), rdat, err);
            check_value(err, 1'b1, "pslverr on command while busy");
        end
        apb_xfer(1'b0, `MC_STAT_ADDR, '0, rdat, err);
        check_value(rdat, 32'(stat_model), "status after command");
        if (e.exp_err) begin
            repeat (first_lat + 4) @(posedge clk);
            #1;
            check_value(words.size(), 0, "words from a rejected command");
            return;
        end
        while (words.size() < e.len) @(posedge clk);
        repeat (4) @(posedge clk);     // catch any extra words
        #1;
        check_value(words.size(), e.len, "word count");
        check_value(stamps[0] - acc, first_lat, "first word latency");
        for (int k = 0; k < words.size() && k < e.len; k++) begin
            check_value(words[k], model[e.chn][k], $sformatf("chn %0d word %0d", e.chn, k));
            check_value(stamps[k] - stamps[0], k, "word spacing");
        end
        stat_model[e.chn] = 1'b1;
        apb_xfer(1'b0, `MC_STAT_ADDR, '0, rdat, err);
        check_value(rdat, 32'(stat_model), "status after burst");
    endtask

    initial begin
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        stat_model = '0;
        // fills, bursts and a fixed margin per table row
        cyc_limit = `MC_NUM_CHN * fill_cycles + 100;
        foreach (cmd_tab[i]) begin
            cyc_limit += cmd_tab[i].len + 40 + (cmd_tab[i].refill ? fill_cycles : 0);
        end
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        for (int c = 0; c < `MC_NUM_CHN; c++) fill_channel(c);
        foreach (cmd_tab[i]) run_entry(cmd_tab[i]);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: bench/mcont_wr_path_chk.sv
// protocol checks for the write path
// read bus, slice valid and output stream rules, bound into the top level
`timescale 1ns/1ns
`include "mcont_params.svh"

module mcont_wr_path_chk
    import mcont_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input buf_rd_bus_t            rd_bus,
    input logic [`MC_NUM_CHN-1:0] slice_rvalid,
    input logic                   busy,
    input mem_word_t              mem_out,
    input logic                   pready
);

    int idle_cnt;  // cycles since busy dropped, saturates

    always_ff @(posedge clk or posedge rst) begin
        if (rst)             idle_cnt <= 100;
        else if (busy)       idle_cnt <= 0;
        else if (idle_cnt < 100) idle_cnt <= idle_cnt + 1;
    end

    a_one_valid: assert property (@(posedge clk) disable iff (rst) $onehot0(slice_rvalid))
        else $error("more than one slice rvalid high");

    a_rchn_stable: assert property (@(posedge clk) disable iff (rst)
        rd_bus.rd |-> $stable(rd_bus.rchn))
        else $error("rchn changed while rd high");

    // the last word leaves 2+latency cycles after busy drops
    a_no_idle_out: assert property (@(posedge clk) disable iff (rst)
        mem_out.valid |-> (busy || idle_cnt <= 2 + `MC_CHN_LATENCY))
        else $error("mem_out valid while idle");

    a_pready: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready low");

endmodule

bind mcont_wr_path mcont_wr_path_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .rd_bus       (rd_bus),
    .slice_rvalid (slice_rvalid),
    .busy         (busy),
    .mem_out      (mem_out),
    .pready       (pready)
);

// File: verilog/mcont_wr_path.sv
// memory controller write data path
// APB filled channel buffers, a command sequencer, per-channel read
// register slices and a merged memory-side output stream
`timescale 1ns/1ns
`include "mcont_params.svh"

module mcont_wr_path
    import mcont_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`MC_APB_AW-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output mem_word_t             mem_out
);

    buf_fill_t              fill [`MC_NUM_CHN];
    logic [`MC_NUM_CHN-1:0] fill_we;
    logic [`MC_NUM_CHN-1:0] chn_done;      // slice done pulses
    chn_cmd_t               cmd;
    logic                   start;
    logic                   busy;
    buf_rd_bus_t            rd_bus;        // shared read bus
    logic [`MC_NUM_CHN-1:0] buf_rd;
    logic [`MC_NUM_CHN-1:0] buf_raddr_rst;
    logic [`MC_DW-1:0]      buf_rdata [`MC_NUM_CHN];
    logic [`MC_DW-1:0]      slice_rdata [`MC_NUM_CHN];
    logic [`MC_NUM_CHN-1:0] slice_rvalid;

    chn_apb_regs u_apb_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .fill     (fill),
        .fill_we  (fill_we),
        .cmd      (cmd),
        .start    (start),
        .busy     (busy),
        .chn_done (chn_done)
    );

    chn_read_seq u_read_seq (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .start  (start),
        .busy   (busy),
        .rd_bus (rd_bus)
    );

    for (genvar i = 0; i < `MC_NUM_CHN; i++) begin : g_chn
        chnbuf_read_reg #(
            .chn_number  (i),
            .chn_latency (`MC_CHN_LATENCY)
        ) u_read_reg (
            .clk           (clk),
            .rst           (rst),
            .rd_bus        (rd_bus),
            .buf_rd        (buf_rd[i]),
            .buf_raddr_rst (buf_raddr_rst[i]),
            .buf_rdata     (buf_rdata[i]),
            .rdata         (slice_rdata[i]),
            .rvalid        (slice_rvalid[i]),
            .buf_done      (chn_done[i])
        );

        chn_buffer #(
            .chn_latency (`MC_CHN_LATENCY)
        ) u_buffer (
            .clk       (clk),
            .rst       (rst),
            .fill      (fill[i]),
            .fill_we   (fill_we[i]),
            .rd        (buf_rd[i]),
            .raddr_rst (buf_raddr_rst[i]),
            .rdata     (buf_rdata[i])
        );
    end

    wr_data_merge u_merge (
        .clk     (clk),
        .rst     (rst),
        .rdata   (slice_rdata),
        .rvalid  (slice_rvalid),
        .mem_out (mem_out)
    );

endmodule

// File: verilog/wr_data_merge.sv
// write data merge
// ORs the read data of the slice with valid set (at most one per cycle)
// and registers it as the memory-side word
`timescale 1ns/1ns
`include "mcont_params.svh"

module wr_data_merge
    import mcont_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`MC_DW-1:0]      rdata [`MC_NUM_CHN],
    input  logic [`MC_NUM_CHN-1:0] rvalid,
    output mem_word_t              mem_out
);

    logic [`MC_DW-1:0] merged;
    logic              out_vld;
    logic [`MC_DW-1:0] out_data;

    always_comb begin
        merged = '0;
        for (int i = 0; i < `MC_NUM_CHN; i++) begin
            if (rvalid[i]) merged |= rdata[i]; // idle slices contribute zero
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) out_vld <= 1'b0;
        else     out_vld <= |rvalid;
    end

    always_ff @(posedge clk) begin
        out_data <= merged;
    end

    assign mem_out = '{valid: out_vld, data: out_data};

endmodule

// File: verilog/chnbuf_read_reg.sv
// channel read register slice
// registers the shared read bus toward one channel buffer and captures
// the buffer read data into a registered word with a valid pulse
`timescale 1ns/1ns
`include "mcont_params.svh"

module chnbuf_read_reg
    import mcont_pkg::*;
#(
    parameter int chn_number  = 0,
    parameter int chn_latency = 0  // must match the buffer
)(
    input  logic              clk,
    input  logic              rst,
    input  buf_rd_bus_t       rd_bus,
    output logic              buf_rd,
    output logic              buf_raddr_rst,
    input  logic [`MC_DW-1:0] buf_rdata,
    output logic [`MC_DW-1:0] rdata,
    output logic              rvalid,
    output logic              buf_done
);

    logic                 chn_hit;  // bus addresses this channel
    logic                 chn_sel;  // registered match
    logic [chn_latency:0] lat_sr;   // reads in flight

    assign chn_hit = (rd_bus.rchn == `MC_CHN_W'(chn_number));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chn_sel       <= 1'b0;
            buf_rd        <= 1'b0;
            buf_raddr_rst <= 1'b0;
            buf_done      <= 1'b0;
            lat_sr        <= '0;
            rvalid        <= 1'b0;
        end else begin
            chn_sel       <= chn_hit;
            buf_rd        <= chn_sel && rd_bus.rd;
            buf_raddr_rst <= chn_hit && rd_bus.raddr_rst; // rchn valid with the pulse
            buf_done      <= chn_sel && rd_bus.seq_done;
            lat_sr        <= (lat_sr << 1) | (chn_latency+1)'(buf_rd);
            rvalid        <= lat_sr[chn_latency];
        end
    end

    // data lands with the top bit of the tracker
    always_ff @(posedge clk) begin
        if (lat_sr[chn_latency]) rdata <= buf_rdata;
    end

endmodule

// File: verilog/chn_read_seq.sv
// read sequencer
// turns an accepted command into the shared read bus sequence:
// channel select with address restart, len read strobes, then done
`timescale 1ns/1ns
`include "mcont_params.svh"

module chn_read_seq
    import mcont_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  chn_cmd_t    cmd,
    input  logic        start,
    output logic        busy,
    output buf_rd_bus_t rd_bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEL,   // rchn set, address restart
        ST_READ,  // read strobes
        ST_DONE   // seq_done pulse
    } seq_state_t;

    seq_state_t          state;
    logic [`MC_BUF_AW:0] cnt;   // reads left including the current one

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            cnt    <= '0;
            busy   <= 1'b0;
            rd_bus <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        rd_bus.rchn      <= cmd.chn; // held until the next command
                        rd_bus.raddr_rst <= 1'b1;
                        cnt              <= cmd.len;
                        busy             <= 1'b1;
                        state            <= ST_SEL;
                    end
                end
                ST_SEL: begin
                    rd_bus.raddr_rst <= 1'b0;
                    rd_bus.rd        <= 1'b1;        // first strobe at S+2
                    state            <= ST_READ;
                end
                ST_READ: begin
                    if (cnt == 1) begin
                        rd_bus.rd       <= 1'b0;
                        rd_bus.seq_done <= 1'b1;     // S+2+len
                        state           <= ST_DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_DONE: begin
                    rd_bus.seq_done <= 1'b0;
                    busy            <= 1'b0;         // low from S+3+len
                    state           <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/chn_buffer.sv
// channel data buffer
// 128 x 64 bit words written from APB in 32-bit halves, read sequentially
// from word 0 through an address counter, output after chn_latency+1 stages
`timescale 1ns/1ns
`include "mcont_params.svh"

module chn_buffer
    import mcont_pkg::*;
#(
    parameter int chn_latency = 0   // extra output register stages
)(
    input  logic              clk,
    input  logic              rst,
    input  buf_fill_t         fill,
    input  logic              fill_we,
    input  logic              rd,
    input  logic              raddr_rst,
    output logic [`MC_DW-1:0] rdata
);

    localparam int depth = 1 << `MC_BUF_AW;

    logic [`MC_DW-1:0]     mem [depth];
    logic [`MC_BUF_AW-1:0] raddr;               // next word to read
    logic [`MC_DW-1:0]     pipe [chn_latency+1]; // read data stages

    // write port, one half per APB write
    always_ff @(posedge clk) begin
        if (fill_we) begin
            if (fill.half) mem[fill.word][`MC_DW-1 -: 32] <= fill.data;
            else           mem[fill.word][31:0]          <= fill.data;
        end
    end

    // read address, restart has priority over advance
    always_ff @(posedge clk or posedge rst) begin
        if (rst)            raddr <= '0;
        else if (raddr_rst) raddr <= '0;
        else if (rd)        raddr <= raddr + 1'b1;
    end

    // first stage loads only on a strobe, the rest shift every cycle
    always_ff @(posedge clk) begin
        if (rd) pipe[0] <= mem[raddr];
        for (int i = 1; i <= chn_latency; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign rdata = pipe[chn_latency]; // valid chn_latency+1 cycles after rd

endmodule

// File: verilog/chn_apb_regs.sv
// APB slave of the write path
// decodes buffer fill writes and the command register, rejects illegal
// commands and keeps one sticky done bit per channel
`timescale 1ns/1ns
`include "mcont_params.svh"

module chn_apb_regs
    import mcont_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`MC_APB_AW-1:0]  paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output buf_fill_t              fill [`MC_NUM_CHN],
    output logic [`MC_NUM_CHN-1:0] fill_we,
    output chn_cmd_t               cmd,
    output logic                   start,
    input  logic                   busy,
    input  logic [`MC_NUM_CHN-1:0] chn_done
);

    logic                   wr_acc;    // write in access phase
    logic                   rd_acc;
    logic                   fill_hit;
    logic                   cmd_hit;
    logic                   cmd_ok;    // command accepted this cycle
    chn_cmd_t               cmd_w;     // command as seen on pwdata
    buf_fill_t              fill_q;
    logic                   fill_vld;
    logic [`MC_NUM_CHN-1:0] stat;      // sticky done bits

    assign wr_acc   = psel && penable && pwrite;
    assign rd_acc   = psel && penable && !pwrite;
    assign fill_hit = wr_acc && !paddr[`MC_FILL_SEL_BIT];
    assign cmd_hit  = wr_acc && (paddr == `MC_CMD_ADDR);

    assign cmd_w.chn = pwdata[`MC_CMD_CHN_LSB +: `MC_CHN_W];
    assign cmd_w.len = pwdata[`MC_BUF_AW:0];
    // start still pending counts as busy
    assign cmd_ok    = cmd_hit && !busy && !start && (cmd_w.len != '0);

    assign pready  = 1'b1;              // zero wait states
    assign pslverr = cmd_hit && !cmd_ok; // only bad commands error
    assign prdata  = (rd_acc && paddr == `MC_STAT_ADDR) ? 32'(stat) : '0;

    // buffer fill, one cycle after the access phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) fill_vld <= 1'b0;
        else     fill_vld <= fill_hit;
    end

    always_ff @(posedge clk) begin
        if (fill_hit) begin
            fill_q.chn  <= paddr[`MC_FILL_CHN_LSB +: `MC_CHN_W];
            fill_q.word <= paddr[`MC_FILL_WORD_LSB +: `MC_BUF_AW];
            fill_q.half <= paddr[`MC_FILL_HALF_BIT];
            fill_q.data <= pwdata;
        end
    end

    always_comb begin
        for (int i = 0; i < `MC_NUM_CHN; i++) begin
            fill[i]    = fill_q;                                   // same word to all
            fill_we[i] = fill_vld && (fill_q.chn == `MC_CHN_W'(i)); // only owner writes
        end
    end

    // command hand-off, start pulse one cycle after accept
    always_ff @(posedge clk or posedge rst) begin
        if (rst) start <= 1'b0;
        else     start <= cmd_ok;
    end

    always_ff @(posedge clk) begin
        if (cmd_ok) cmd <= cmd_w;
    end

    // done status, a new command on a channel clears its bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stat <= '0;
        end else begin
            for (int i = 0; i < `MC_NUM_CHN; i++) begin
                if (cmd_ok && cmd_w.chn == `MC_CHN_W'(i)) stat[i] <= 1'b0;
                else if (chn_done[i])                    stat[i] <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/mcont_pkg.sv
// write path types
// packed structs passed between the APB slave, sequencer, channel slices
// and the memory-side output
`include "mcont_params.svh"

package mcont_pkg;

    // command accepted by the APB slave
    typedef struct packed {
        logic [`MC_CHN_W-1:0]  chn;     // target channel
        logic [`MC_BUF_AW:0]   len;     // burst length in words, 1..128
    } chn_cmd_t;

    // shared read bus, sequencer to every channel slice
    typedef struct packed {
        logic [`MC_CHN_W-1:0]  rchn;      // channel, valid one cycle ahead of rd
        logic                  rd;        // read strobe
        logic                  raddr_rst; // restart buffer address at word 0
        logic                  seq_done;  // burst finished
    } buf_rd_bus_t;

    // one 32-bit buffer write from APB
    typedef struct packed {
        logic [`MC_CHN_W-1:0]  chn;
        logic [`MC_BUF_AW-1:0] word;
        logic                  half;    // 1 writes the upper 32 bits
        logic [31:0]           data;
    } buf_fill_t;

    // memory-side output word
    typedef struct packed {
        logic                  valid;
        logic [`MC_DW-1:0]     data;
    } mem_word_t;

endpackage

// File: verilog/mcont_params.svh
// memory controller write path, shared sizes and APB address map
// channel count, buffer geometry, read latency and register decode
`ifndef MCONT_PARAMS_SVH
`define MCONT_PARAMS_SVH

// channels and buffers
`define MC_NUM_CHN      4       // number of channel buffers
`define MC_CHN_W        2       // channel index width
`define MC_BUF_AW       7       // word address width, 128 words per buffer
`define MC_DW           64      // read data width
`define MC_CHN_LATENCY  1       // extra buffer read stages beyond the first

// APB address map
`define MC_APB_AW       13
`define MC_FILL_SEL_BIT 12      // low selects buffer fill, high selects registers
`define MC_FILL_CHN_LSB 10      // paddr[11:10] channel
`define MC_FILL_WORD_LSB 3      // paddr[9:3] word index
`define MC_FILL_HALF_BIT 2      // 0 low half, 1 high half
`define MC_CMD_ADDR     13'h1000
`define MC_STAT_ADDR    13'h1004

// command register layout
// pwdata[MC_BUF_AW:0] is the burst length, pwdata[17:16] the channel
`define MC_CMD_CHN_LSB  16

`endif
